// ==== files.f ====
+incdir+design
design/pkt_exe_pkg.sv
design/sync_fifo.sv
design/cpu_poll_counter.sv
design/hdr_rewrite.sv
design/exe_ctrl_fsm.sv
design/pkt_exe_top.sv
verif/pkt_exe_assert.sv
verif/pkt_exe_tb.sv

// ==== Bender.yml ====
package:
  name: pkt_exe

export_include_dirs:
  - design

sources:
  - include_dirs:
      - design
    files:
      - design/pkt_exe_pkg.sv
      - design/sync_fifo.sv
      - design/cpu_poll_counter.sv
      - design/hdr_rewrite.sv
      - design/exe_ctrl_fsm.sv
      - design/pkt_exe_top.sv
  - target: simulation
    include_dirs:
      - design
    files:
      - verif/pkt_exe_assert.sv
      - verif/pkt_exe_tb.sv

// ==== verif/pkt_exe_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "pkt_exe_consts.svh"

module pkt_exe_tb import pkt_exe_pkg::*;;
    localparam int NUM_PKTS       = 40;
    localparam int SYS_MAX        = 5;
    localparam int TIMEOUT_CYCLES = NUM_PKTS * 12 + 200;   // 6 words, 6 gaps worst case

    logic       clk;
    logic       rst_n;
    logic       pkt_wr;
    pkt_word_t  pkt_data;
    logic       rule_wr;
    rule_t      rule_data;
    logic [5:0] sys_max_cpuid;
    logic       pkt_af;
    logic       rule_af;
    logic       out_wr;
    logic       out_eop;
    pkt_word_t  out_data;

    logic [31:0] lfsr = 32'h6252980e;
    pkt_word_t   exp_q[$];       // expected output words in order
    int          poll_count = 0; // code-2 packets sent so far
    int          words_sent = 0; // upper bound on packet fifo fill
    int          rules_sent = 0;
    int          cycles = 0;
    logic        af_hold = 1'b0;

    pkt_exe_top i_pkt_exe_top (
        .clk           (clk),
        .rst_n         (rst_n),
        .pkt_wr        (pkt_wr),
        .pkt_data      (pkt_data),
        .rule_wr       (rule_wr),
        .rule_data     (rule_data),
        .sys_max_cpuid (sys_max_cpuid),
        .pkt_af        (pkt_af),
        .rule_af       (rule_af),
        .out_wr        (out_wr),
        .out_eop       (out_eop),
        .out_data      (out_data)
    );

    bind pkt_exe_top pkt_exe_assert u_assert (
        .clk      (clk),
        .rst_n    (rst_n),
        .out_wr   (out_wr),
        .out_eop  (out_eop),
        .out_data (out_data),
        .state    (u_fsm.state)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic fail_now(input string why);
        $display("%s", why);
        $display("Test FAILED");
        $fatal(1, "stopping on first error");
    endtask

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[30:0], lfsr[0]};   // one step per bit
        end
    endtask

    task automatic take_body(output logic [131:0] b);
        logic [31:0] v;
        b = '0;
        for (int k = 0; k < 4; k++) begin
            take_bits(32, v);
            b = {b[99:0], v};
        end
        take_bits(4, v);
        b = {b[127:0], v[3:0]};
    endtask

    // header as dispatch should see it
    function automatic pkt_word_t expect_header(input pkt_word_t w, input rule_t r,
                                                input int pid);
        pkt_hdr_t h;
        h = pkt_hdr_t'(w);
        if (r.action == `ACT_CPU_USER) begin
            h.cpu_thread = 9'(r.arg);
        end else if (r.action == `ACT_CPU_POLL) begin
            h.cpu_thread = 9'(pid);
        end else if (r.arg[7:4] == 4'd0) begin
            h.out_slot = 3'd0;
            h.out_port = 10'(r.arg[3:0]);
        end else begin
            h.out_slot = 3'd1;
            h.out_port = 10'(r.arg[7:4]);
        end
        return pkt_word_t'(h);
    endfunction

    task automatic put_word(input pkt_word_t w, input logic with_rule, input rule_t r);
        while (af_hold) begin   // upstream holds off on almost full
            pkt_wr  <= 1'b0;
            rule_wr <= 1'b0;
            @(posedge clk);
        end
        words_sent++;
        if (with_rule) begin
            rules_sent++;
        end
        pkt_wr    <= 1'b1;
        pkt_data  <= w;
        rule_wr   <= with_rule;
        rule_data <= r;
        @(posedge clk);
    endtask

    task automatic send_packet(input int idx);
        logic [31:0] v;
        rule_t       r;
        pkt_word_t   w;
        int          len;
        logic        fwd;
        take_bits(3, v);
        r.action = 4'(v % 5);
        take_bits(20, v);
        r.misc = v[19:0];
        take_bits(8, v);
        r.arg = v[7:0];
        if (idx == 0) begin
            r.action   = `ACT_PORT;
            r.arg[7:4] = 4'd0;   // slot 0 case
        end else if (idx == 1) begin
            r.action = `ACT_PORT;
            r.arg[7] = 1'b1;     // slot 1 case
        end
        take_bits(3, v);
        len = 2 + int'(v % 5);
        fwd = (r.action == `ACT_CPU_USER) || (r.action == `ACT_CPU_POLL) ||
              (r.action == `ACT_PORT);
        for (int i = 0; i < len; i++) begin
            w.pos = (i == 0) ? 2'b01 : ((i == len - 1) ? 2'b10 : 2'b11);
            take_body(w.body);
            if (fwd) begin
                // ids run 0 .. SYS_MAX-1 and start over
                exp_q.push_back((i == 0) ? expect_header(w, r, poll_count % SYS_MAX) : w);
            end
            put_word(w, i == 0, r);
            take_bits(1, v);
            if (v[0]) begin   // idle gap
                pkt_wr  <= 1'b0;
                rule_wr <= 1'b0;
                @(posedge clk);
            end
        end
        if (r.action == `ACT_CPU_POLL) begin
            poll_count++;
        end
    endtask

    // scoreboard
    always @(posedge clk) begin
        pkt_word_t exp_w;
        if (out_wr) begin
            assert (exp_q.size() != 0)
                else fail_now("out_wr pulsed with no output word expected");
            exp_w = exp_q.pop_front();
            assert (out_data == exp_w)
                else fail_now($sformatf("MISMATCH at %0t: out_data expected %h actual %h",
                                        $time, exp_w, out_data));
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        assert (cycles < TIMEOUT_CYCLES)
            else fail_now("timeout, the expected output words did not all arrive");
    end

    always @(negedge clk) begin
        af_hold <= pkt_af || rule_af;
        assert (i_pkt_exe_top.u_assert.fail_count == 0)
            else fail_now("a protocol assertion in pkt_exe_assert failed");
        // fewer entries than the threshold ever went in
        if (words_sent < `PKT_FIFO_DEPTH - `FIFO_AF_MARGIN) begin
            assert (!pkt_af)
                else fail_now($sformatf("MISMATCH at %0t: pkt_af expected 0 actual %b",
                                        $time, pkt_af));
        end
        if (rules_sent < `RULE_FIFO_DEPTH - `FIFO_AF_MARGIN) begin
            assert (!rule_af)
                else fail_now($sformatf("MISMATCH at %0t: rule_af expected 0 actual %b",
                                        $time, rule_af));
        end
    end

    initial begin
        rst_n         = 1'b0;
        pkt_wr        = 1'b0;
        pkt_data      = '0;
        rule_wr       = 1'b0;
        rule_data     = '0;
        sys_max_cpuid = 6'(SYS_MAX);
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        for (int p = 0; p < NUM_PKTS; p++) begin
            send_packet(p);
        end
        pkt_wr  <= 1'b0;
        rule_wr <= 1'b0;
        @(negedge clk);
        // all words delivered and trailing discards drained
        while (exp_q.size() != 0 || !i_pkt_exe_top.pkt_empty ||
               i_pkt_exe_top.u_fsm.state != IDLE) begin
            @(negedge clk);
        end
        @(negedge clk);   // strobe of the last pop reaches the scoreboard
        if (i_pkt_exe_top.u_assert.fail_count == 0) begin
            $display("Test OK");
            $finish;
        end else begin
            fail_now("run ended with failed protocol checks");
        end
    end

endmodule

`default_nettype wire

// ==== verif/pkt_exe_assert.sv ====
`timescale 1ns/10ps
`default_nettype none

module pkt_exe_assert import pkt_exe_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       out_wr,
    input  logic       out_eop,
    input  pkt_word_t  out_data,
    input  exe_state_t state
);
    int unsigned fail_count = 0;   // watched by the testbench
    logic        pair_seen;        // a header and its rule were popped

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pair_seen <= 1'b0;
        end else if (state == META) begin
            pair_seen <= 1'b1;
        end
    end

    // eop only with a delivered tail word
    eop_on_tail: assert property (@(posedge clk) disable iff (!rst_n)
        out_eop |-> out_wr && (out_data.pos == 2'b10))
        else begin
            $error("out_eop high without a tail word on out_data");
            fail_count++;
        end

    tail_has_eop: assert property (@(posedge clk) disable iff (!rst_n)
        (out_wr && (out_data.pos == 2'b10)) |-> out_eop)
        else begin
            $error("tail word delivered without out_eop");
            fail_count++;
        end

    no_wr_in_discard: assert property (@(posedge clk) disable iff (!rst_n)
        (state == DISCARD) |-> !out_wr)
        else begin
            $error("out_wr high while the FSM discards a packet");
            fail_count++;
        end

    quiet_before_pair: assert property (@(posedge clk) disable iff (!rst_n)
        !pair_seen |-> !out_wr && !out_eop)
        else begin
            $error("output strobe before any header and rule pair");
            fail_count++;
        end

    // header leaves one cycle after META
    head_after_meta: assert property (@(posedge clk) disable iff (!rst_n)
        (out_wr && (out_data.pos == 2'b01)) |-> ($past(state) == META))
        else begin
            $error("header word delivered without a META cycle before it");
            fail_count++;
        end

endmodule

`default_nettype wire

// ==== design/pkt_exe_top.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "pkt_exe_consts.svh"

module pkt_exe_top import pkt_exe_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       pkt_wr,
    input  pkt_word_t  pkt_data,
    input  logic       rule_wr,
    input  rule_t      rule_data,
    input  logic [5:0] sys_max_cpuid,
    output logic       pkt_af,
    output logic       rule_af,
    output logic       out_wr,
    output logic       out_eop,
    output pkt_word_t  out_data
);
    pkt_word_t  pkt_head;
    logic       pkt_empty;
    logic       pkt_rd;
    rule_t      rule_head;
    logic       rule_empty;
    logic       rule_rd;
    logic [5:0] poll_id;
    logic       poll_advance;
    pkt_word_t  hdr_new;

    // upstream stops on almost_full, so full is never reached
    sync_fifo #(
        .payload_t (pkt_word_t),
        .DEPTH     (`PKT_FIFO_DEPTH)
    ) u_pkt_fifo (
        .clk         (clk),
        .rst_n       (rst_n),
        .wr          (pkt_wr),
        .wdata       (pkt_data),
        .rd          (pkt_rd),
        .rdata       (pkt_head),
        .empty       (pkt_empty),
        .full        (),
        .almost_full (pkt_af)
    );

    sync_fifo #(
        .payload_t (rule_t),
        .DEPTH     (`RULE_FIFO_DEPTH)
    ) u_rule_fifo (
        .clk         (clk),
        .rst_n       (rst_n),
        .wr          (rule_wr),
        .wdata       (rule_data),
        .rd          (rule_rd),
        .rdata       (rule_head),
        .empty       (rule_empty),
        .full        (),
        .almost_full (rule_af)
    );

    cpu_poll_counter u_poll (
        .clk     (clk),
        .rst_n   (rst_n),
        .advance (poll_advance),
        .max_id  (sys_max_cpuid),
        .poll_id (poll_id)
    );

    hdr_rewrite u_hdr (
        .hdr_in  (pkt_head),
        .rule    (rule_head),
        .poll_id (poll_id),
        .hdr_out (hdr_new)
    );

    exe_ctrl_fsm u_fsm (
        .clk          (clk),
        .rst_n        (rst_n),
        .pkt_empty    (pkt_empty),
        .pkt_head     (pkt_head),
        .rule_empty   (rule_empty),
        .rule_head    (rule_head),
        .hdr_new      (hdr_new),
        .pkt_rd       (pkt_rd),
        .rule_rd      (rule_rd),
        .poll_advance (poll_advance),
        .out_wr       (out_wr),
        .out_eop      (out_eop),
        .out_data     (out_data)
    );

endmodule

`default_nettype wire

// ==== design/exe_ctrl_fsm.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "pkt_exe_consts.svh"

module exe_ctrl_fsm import pkt_exe_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      pkt_empty,
    input  pkt_word_t pkt_head,
    input  logic      rule_empty,
    input  rule_t     rule_head,
    input  pkt_word_t hdr_new,
    output logic      pkt_rd,
    output logic      rule_rd,
    output logic      poll_advance,
    output logic      out_wr,
    output logic      out_eop,
    output pkt_word_t out_data
);
    exe_state_t state;
    exe_state_t state_nxt;
    logic       act_fwd;    // rule delivers the packet somewhere
    logic       body_pop;   // body word leaves the packet fifo
    logic       tail_pop;

    assign act_fwd = (rule_head.action == `ACT_CPU_USER) ||
                     (rule_head.action == `ACT_CPU_POLL) ||
                     (rule_head.action == `ACT_PORT);

    // TRANS and DISCARD drain one word per cycle while data is there
    assign body_pop = ((state == TRANS) || (state == DISCARD)) && !pkt_empty;
    assign tail_pop = body_pop && (pkt_head.pos == 2'b10);

    // header and rule leave together in META,
    // both fifos were seen non-empty in IDLE
    assign pkt_rd       = (state == META) || body_pop;
    assign rule_rd      = (state == META);
    assign poll_advance = (state == META) && (rule_head.action == `ACT_CPU_POLL);

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (!pkt_empty && !rule_empty) begin
                    state_nxt = META;
                end
            end
            META: begin
                state_nxt = act_fwd ? TRANS : DISCARD;
            end
            TRANS: begin
                if (tail_pop) begin
                    state_nxt = IDLE;
                end
            end
            DISCARD: begin
                if (tail_pop) begin
                    state_nxt = IDLE;
                end
            end
            default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // output strobes, one cycle behind the pop
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_wr  <= 1'b0;
            out_eop <= 1'b0;
        end else begin
            out_wr  <= ((state == META) && act_fwd) || (body_pop && (state == TRANS));
            out_eop <= tail_pop && (state == TRANS);
        end
    end

    // rewritten header in META, raw word otherwise
    always_ff @(posedge clk) begin
        if (state == META) begin
            out_data <= hdr_new;
        end else if (body_pop) begin
            out_data <= pkt_head;   // discarded words land here too, out_wr stays low
        end
    end

endmodule

`default_nettype wire

// ==== design/hdr_rewrite.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "pkt_exe_consts.svh"

module hdr_rewrite import pkt_exe_pkg::*; (
    input  pkt_word_t  hdr_in,
    input  rule_t      rule,
    input  logic [5:0] poll_id,
    output pkt_word_t  hdr_out
);
    pkt_hdr_t hdr;
    logic     port_hi;   // upper port nibble set, goes to slot 1

    assign port_hi = (rule.arg[7:4] != 4'd0);

    always_comb begin
        hdr = pkt_hdr_t'(hdr_in);
        case (rule.action)
            `ACT_CPU_USER: begin
                hdr.cpu_thread = {1'b0, rule.arg};
            end
            `ACT_CPU_POLL: begin
                hdr.cpu_thread = {3'b000, poll_id};
            end
            `ACT_PORT: begin
                if (port_hi) begin
                    hdr.out_slot = 3'd1;
                    hdr.out_port = {6'd0, rule.arg[7:4]};
                end else begin
                    hdr.out_slot = 3'd0;
                    hdr.out_port = {6'd0, rule.arg[3:0]};
                end
            end
            default: begin
                // packet is dropped by the fsm, word left as is
                hdr = pkt_hdr_t'(hdr_in);
            end
        endcase
    end

    assign hdr_out = pkt_word_t'(hdr);

endmodule

`default_nettype wire

// ==== design/cpu_poll_counter.sv ====
`timescale 1ns/10ps
`default_nettype none

module cpu_poll_counter (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       advance,
    input  logic [5:0] max_id,
    output logic [5:0] poll_id
);
    logic [6:0] id_inc;   // one extra bit so 63 + 1 does not wrap

    // compare id + 1 against max rather than id against max - 1,
    // max_id of zero would underflow otherwise
    assign id_inc = {1'b0, poll_id} + 7'd1;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            poll_id <= '0;
        end else if (advance) begin
            if (id_inc < {1'b0, max_id}) begin
                poll_id <= id_inc[5:0];
            end else begin
                poll_id <= '0;   // wrap
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/sync_fifo.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "pkt_exe_consts.svh"

module sync_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = 16
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     wr,
    input  payload_t wdata,
    input  logic     rd,
    output payload_t rdata,
    output logic     empty,
    output logic     full,
    output logic     almost_full
);
    localparam int AW = $clog2(DEPTH);
    localparam int CW = $clog2(DEPTH + 1);

    payload_t        mem [DEPTH];
    logic [AW-1:0]   wr_ptr;
    logic [AW-1:0]   rd_ptr;
    logic [CW-1:0]   count;
    logic            do_wr;
    logic            do_rd;

    assign do_wr = wr && !full;   // overflow writes are dropped
    assign do_rd = rd && !empty;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wdata;
        end
    end

    // head entry falls through, no read latency
    assign rdata       = mem[rd_ptr];
    assign empty       = (count == '0);
    assign full        = (count == CW'(DEPTH));
    assign almost_full = (count >= CW'(DEPTH - `FIFO_AF_MARGIN));

endmodule

`default_nettype wire

// ==== design/pkt_exe_pkg.sv ====
`default_nettype none

package pkt_exe_pkg;

    // word as it travels through the pipeline
    typedef struct packed {
        logic [1:0]   pos;       // 01 head, 11 middle, 10 tail
        logic [131:0] body;
    } pkt_word_t;

    // header word view, msb first
    typedef struct packed {
        logic [1:0]   pos;
        logic [18:0]  misc_a;
        logic [2:0]   out_slot;  // [112:110]
        logic [35:0]  misc_b;
        logic [9:0]   out_port;  // [73:64]
        logic [7:0]   misc_c;
        logic [8:0]   cpu_thread; // [55:47]
        logic [46:0]  misc_d;
    } pkt_hdr_t;

    // lookup result, one per packet
    typedef struct packed {
        logic [3:0]   action;
        logic [19:0]  misc;      // not used in this stage
        logic [7:0]   arg;       // thread id or port nibbles
    } rule_t;

    typedef enum logic [1:0] {
        IDLE    = 2'd0,
        META    = 2'd1,   // header word and rule popped here
        TRANS   = 2'd2,
        DISCARD = 2'd3
    } exe_state_t;

endpackage

`default_nettype wire

// ==== design/pkt_exe_consts.svh ====
`ifndef PKT_EXE_CONSTS_SVH
`define PKT_EXE_CONSTS_SVH

// fifo sizing
`define PKT_FIFO_DEPTH   256    // packet words
`define RULE_FIFO_DEPTH  64     // one rule per packet

// almost_full rises with this many free entries left,
// leaves room for words already in flight upstream
`define FIFO_AF_MARGIN   8

// rule action codes
`define ACT_CPU_USER     4'd1   // to cpu, thread id from rule
`define ACT_CPU_POLL     4'd2   // to cpu, round-robin thread id
`define ACT_PORT         4'd3   // to output port, slot 0 or 1

`endif
